//--- common/mem_pkg.sv
// shared sizes and encodings; word access only, the mapped range starts at byte 0
package mem_pkg;

  // --------------------
  // sizes
  // --------------------

  // bus address width
  localparam int ADDR_W    = 32;
  // data word width
  localparam int DATA_W    = 32;
  // array depth in words
  localparam int MEM_WORDS = 1024;
  // word index width, log2 of depth
  localparam int WORD_AW   = 10;
  // byte size of mapped range, anything at or above is illegal
  localparam int MEM_BYTES = 4096;

  // --------------------
  // encodings
  // --------------------

  // ahb transfer type, only nonseq and seq start a transfer
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // port decoder state, one transfer in flight
  typedef enum logic {
    PORT_IDLE,
    PORT_WAIT_DONE
  } port_state_e;

  // access engine state in clk_mem
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_ACCESS,
    SYNC_REPLY
  } sync_state_e;

endpackage

//--- common/mem_req_if.sv
// one port request across clock domains; addr, write and wdata must stay stable until done
interface mem_req_if;
  import mem_pkg::*;

  // two-phase request, flips once per legal transfer
  logic               req_tgl;
  // word index, not byte address
  logic [WORD_AW-1:0] addr;
  logic               write;
  logic [DATA_W-1:0]  wdata;
  // one clk_l2 cycle pulse when the access has finished
  logic               done;
  // read word, held stable by the engine
  logic [DATA_W-1:0]  rdata;

  // decoder side
  modport issue (
    output req_tgl, addr, write, wdata,
    input  done
  );

  // access engine side
  modport serve (
    input  req_tgl, addr, write, wdata,
    output done, rdata
  );

  // response stage only observes
  modport watch (
    input done, rdata
  );

endinterface

//--- common/mem_sram_if.sv
// single sram port in clk_mem; rdata is registered, valid one edge after en
interface mem_sram_if;
  import mem_pkg::*;

  // access strobe, one cycle per access
  logic               en;
  // write when set together with en
  logic               wen;
  logic [WORD_AW-1:0] addr;
  logic [DATA_W-1:0]  wdata;
  logic [DATA_W-1:0]  rdata;

  // access engine drives the port
  modport ctrl (
    output en, wen, addr, wdata,
    input  rdata
  );

  // array side
  modport array (
    input  en, wen, addr, wdata,
    output rdata
  );

endinterface

//--- mem/mem_dual_sram.sv
// read-first dual-port array, no reset; both ports writing one word lets port b win
module mem_dual_sram (
  input  logic       clk_mem,
  mem_sram_if.array  port_a,
  mem_sram_if.array  port_b
);
  import mem_pkg::*;

  // word storage, zero at time 0 in simulation
  logic [DATA_W-1:0] mem [MEM_WORDS] = '{default: '0};

  // --------------------
  // both ports
  // --------------------

  // one process owns the array
  always_ff @(posedge clk_mem)
  begin
    if (port_a.en)
    begin
      // nonblocking read returns the old word
      port_a.rdata <= mem[port_a.addr];
      if (port_a.wen)
        mem[port_a.addr] <= port_a.wdata;
    end
    if (port_b.en)
    begin
      port_b.rdata <= mem[port_b.addr];
      // last write wins on a collision
      if (port_b.wen)
        mem[port_b.addr] <= port_b.wdata;
    end
  end

endmodule

//--- mem/mem_port_decode.sv
// one transfer at a time, requests while busy are dropped; word-aligned accesses only
module mem_port_decode #(
  parameter bit PORT_WRITABLE = 1'b1
) (
  input  logic                       clk_l2,
  input  logic                       rst_n,
  input  logic                       hsel,
  input  mem_pkg::htrans_e           htrans,
  input  logic [mem_pkg::ADDR_W-1:0] haddr,
  input  logic                       hwrite,
  input  logic [mem_pkg::DATA_W-1:0] hwdata,
  mem_req_if.issue                   req,
  output logic                       err
);
  import mem_pkg::*;

  port_state_e state;
  logic        active;
  logic        start;
  logic        addr_ok;

  // --------------------
  // request decode
  // --------------------

  // nonseq or seq, busy and idle transfers are no-ops
  assign active  = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
  assign start   = hsel && active && (state == PORT_IDLE);
  // inside the mapped range and word aligned
  assign addr_ok = (haddr < ADDR_W'(MEM_BYTES)) && (haddr[1:0] == 2'b00);

  // --------------------
  // port fsm
  // --------------------

  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= PORT_IDLE;
      req.req_tgl <= 1'b0;
      err         <= 1'b0;
    end
    else
    begin
      // err is a single pulse
      err <= 1'b0;
      case (state)
        PORT_IDLE:
        begin
          if (start)
          begin
            state <= PORT_WAIT_DONE;
            if (addr_ok)
              req.req_tgl <= ~req.req_tgl;
            else
              err <= 1'b1;
          end
        end
        PORT_WAIT_DONE:
        begin
          // bad address finishes the cycle after err, legal one on done
          if (err || req.done)
            state <= PORT_IDLE;
        end
        default: state <= PORT_IDLE;
      endcase
    end
  end

  // payload, held while the request crosses
  always_ff @(posedge clk_l2)
  begin
    if (start && addr_ok)
    begin
      req.addr  <= haddr[WORD_AW+1:2];
      // instruction port forces reads
      req.write <= PORT_WRITABLE && hwrite;
      req.wdata <= PORT_WRITABLE ? hwdata : '0;
    end
  end

  // --------------------
  // checks
  // --------------------

  // a new request only leaves an idle port
  assert property (@(posedge clk_l2) disable iff (!rst_n)
    (req.req_tgl != $past(req.req_tgl)) |-> ($past(state) == PORT_IDLE));

  // every accepted transfer gives err or a req toggle, never both
  assert property (@(posedge clk_l2) disable iff (!rst_n)
    start |=> (err != (req.req_tgl != $past(req.req_tgl))));

endmodule

//--- mem/mem_access_sync.sv
// toggle handshake crossing; assumes req payload is stable from req_tgl flip until done
module mem_access_sync (
  input  logic      clk_l2,
  input  logic      clk_mem,
  input  logic      rst_n,
  mem_req_if.serve  req,
  mem_sram_if.ctrl  sram
);
  import mem_pkg::*;

  sync_state_e       state;
  // request toggle synchronizer in clk_mem
  logic              req_s1;
  logic              req_s2;
  // ack toggle, flips after each access
  logic              ack_tgl;
  logic [DATA_W-1:0] rdata_q;
  // ack toggle synchronizer in clk_l2
  logic              ack_s1;
  logic              ack_s2;
  logic              ack_s3;
  logic              pending;

  // --------------------
  // clk_mem side
  // --------------------

  always_ff @(posedge clk_mem, negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_s1 <= 1'b0;
      req_s2 <= 1'b0;
    end
    else
    begin
      req_s1 <= req.req_tgl;
      req_s2 <= req_s1;
    end
  end

  // request outstanding until the ack toggle catches up
  assign pending = (req_s2 != ack_tgl);

  always_ff @(posedge clk_mem, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= SYNC_IDLE;
      ack_tgl <= 1'b0;
    end
    else
    begin
      case (state)
        SYNC_IDLE:
          if (pending)
            state <= SYNC_ACCESS;
        // sram samples the access on this edge
        SYNC_ACCESS:
          state <= SYNC_REPLY;
        // rdata is valid now, answer back
        SYNC_REPLY:
        begin
          ack_tgl <= ~ack_tgl;
          state   <= SYNC_IDLE;
        end
        default: state <= SYNC_IDLE;
      endcase
    end
  end

  // read word held until the next access
  always_ff @(posedge clk_mem)
  begin
    if (state == SYNC_REPLY)
      rdata_q <= sram.rdata;
  end

  // sram strobe, one cycle in the access state
  assign sram.en    = (state == SYNC_ACCESS);
  assign sram.wen   = sram.en && req.write;
  // payload is quasi-static across the crossing
  assign sram.addr  = req.addr;
  assign sram.wdata = req.wdata;
  assign req.rdata  = rdata_q;

  // --------------------
  // clk_l2 side
  // --------------------

  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_s1 <= 1'b0;
      ack_s2 <= 1'b0;
      ack_s3 <= 1'b0;
    end
    else
    begin
      ack_s1 <= ack_tgl;
      ack_s2 <= ack_s1;
      ack_s3 <= ack_s2;
    end
  end

  // edge of the synced ack, one cycle wide
  assign req.done = ack_s2 ^ ack_s3;

  // --------------------
  // checks
  // --------------------

  // every synced request edge gives exactly one strobe cycle
  assert property (@(posedge clk_mem) disable iff (!rst_n)
    (req_s2 != $past(req_s2)) |=> sram.en ##1 !sram.en);

endmodule

//--- mem/mem_port_result.sv
// one-cycle hreadyout per finished transfer; hrdata only meaningful for reads
module mem_port_result (
  input  logic                       clk_l2,
  input  logic                       rst_n,
  mem_req_if.watch                   done_src,
  input  logic                       err,
  output logic                       hreadyout,
  output logic [mem_pkg::DATA_W-1:0] hrdata,
  output logic                       hresp
);

  // --------------------
  // response register
  // --------------------

  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      hreadyout <= 1'b0;
      hresp     <= 1'b0;
      hrdata    <= '0;
    end
    else
    begin
      // either source ends the transfer
      hreadyout <= done_src.done || err;
      // error flag only for the response cycle
      hresp     <= err;
      // keep last word otherwise
      if (done_src.done)
        hrdata <= done_src.rdata;
    end
  end

  // --------------------
  // checks
  // --------------------

  // decode and engine never finish the same transfer twice
  assert property (@(posedge clk_l2) disable iff (!rst_n)
    !(done_src.done && err));

endmodule

//--- src/main_memory.sv
// two ahb-style slave ports on clk_l2 sharing one array on clk_mem; imem port is read only
module main_memory (
  input  logic                       clk_l2,
  input  logic                       clk_mem,
  input  logic                       rst_n,
  // instruction port
  input  logic                       imem_hsel,
  input  mem_pkg::htrans_e           imem_htrans,
  input  logic [mem_pkg::ADDR_W-1:0] imem_haddr,
  output logic                       imem_hreadyout,
  output logic [mem_pkg::DATA_W-1:0] imem_hrdata,
  output logic                       imem_hresp,
  // data port
  input  logic                       dmem_hsel,
  input  mem_pkg::htrans_e           dmem_htrans,
  input  logic [mem_pkg::ADDR_W-1:0] dmem_haddr,
  input  logic                       dmem_hwrite,
  input  logic [mem_pkg::DATA_W-1:0] dmem_hwdata,
  output logic                       dmem_hreadyout,
  output logic [mem_pkg::DATA_W-1:0] dmem_hrdata,
  output logic                       dmem_hresp
);

  // per port request and sram links
  mem_req_if  imem_req ();
  mem_req_if  dmem_req ();
  mem_sram_if imem_sram ();
  mem_sram_if dmem_sram ();

  // illegal address pulses, decode to result
  logic imem_err;
  logic dmem_err;

  // --------------------
  // instruction chain
  // --------------------

  // write inputs open, decode forces reads
  mem_port_decode #(
    .PORT_WRITABLE (1'b0)
  ) i_imem_decode (
    .clk_l2 (clk_l2),
    .rst_n  (rst_n),
    .hsel   (imem_hsel),
    .htrans (imem_htrans),
    .haddr  (imem_haddr),
    .hwrite (),
    .hwdata (),
    .req    (imem_req.issue),
    .err    (imem_err)
  );

  mem_access_sync i_imem_sync (
    .clk_l2  (clk_l2),
    .clk_mem (clk_mem),
    .rst_n   (rst_n),
    .req     (imem_req.serve),
    .sram    (imem_sram.ctrl)
  );

  mem_port_result i_imem_result (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .done_src  (imem_req.watch),
    .err       (imem_err),
    .hreadyout (imem_hreadyout),
    .hrdata    (imem_hrdata),
    .hresp     (imem_hresp)
  );

  // --------------------
  // data chain
  // --------------------

  mem_port_decode #(
    .PORT_WRITABLE (1'b1)
  ) i_dmem_decode (
    .clk_l2 (clk_l2),
    .rst_n  (rst_n),
    .hsel   (dmem_hsel),
    .htrans (dmem_htrans),
    .haddr  (dmem_haddr),
    .hwrite (dmem_hwrite),
    .hwdata (dmem_hwdata),
    .req    (dmem_req.issue),
    .err    (dmem_err)
  );

  mem_access_sync i_dmem_sync (
    .clk_l2  (clk_l2),
    .clk_mem (clk_mem),
    .rst_n   (rst_n),
    .req     (dmem_req.serve),
    .sram    (dmem_sram.ctrl)
  );

  mem_port_result i_dmem_result (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .done_src  (dmem_req.watch),
    .err       (dmem_err),
    .hreadyout (dmem_hreadyout),
    .hrdata    (dmem_hrdata),
    .hresp     (dmem_hresp)
  );

  // --------------------
  // shared array
  // --------------------

  // port a serves instructions, port b data
  mem_dual_sram i_sram (
    .clk_mem (clk_mem),
    .port_a  (imem_sram.array),
    .port_b  (dmem_sram.array)
  );

endmodule

//--- test/tb_util.svh
// included inside the testbench top; needs lfsr_state, cycle_count, CYCLE_LIMIT and fail_run
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// --------------------
// random source
// --------------------

// galois form of x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

// one lfsr step per bit, p picks the stream
function automatic bit rand_bit(input int p);
  bit out;
  out = lfsr_state[p][0];
  lfsr_state[p] = {1'b0, lfsr_state[p][31:1]};
  if (out)
    lfsr_state[p] = lfsr_state[p] ^ LFSR_TAPS;
  return out;
endfunction

// n bits, first one taken ends up as msb
function automatic logic [31:0] rand_bits(input int p, input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++)
    r = {r[30:0], rand_bit(p)};
  return r;
endfunction

// --------------------
// checking
// --------------------

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
  if (got !== expected)
  begin
    $display("FAIL %s got 0x%08h expected 0x%08h", name, got, expected);
    fail_run();
  end
endtask

// called once per clk_l2 edge
task automatic tick_watchdog();
  cycle_count++;
  if (cycle_count >= CYCLE_LIMIT)
  begin
    $display("run did not finish within %0d clk_l2 cycles", cycle_count);
    fail_run();
  end
endtask

`endif

//--- test/tb_main_memory.sv
// one master per port; imem never reads a word while a dmem write to that word is in flight
module tb_main_memory;
  timeunit 1ns;
  timeprecision 100ps;
  import mem_pkg::*;

  // port select for the shared helpers
  localparam int IMEM      = 0;
  localparam int DMEM      = 1;
  localparam int N_DATA    = 300;
  localparam int N_ILLEGAL = 16;
  localparam int N_IMEM    = 40;
  // per port, both ports run side by side
  localparam int N_CONC    = 80;
  // reset and idle checks take about three operations
  localparam int N_OPS       = 3 + N_DATA + 2 * N_ILLEGAL + 2 * N_IMEM + N_CONC;
  localparam int CYCLE_LIMIT = 12 * N_OPS + 100;

  logic              clk_l2;
  logic              clk_mem;
  logic              rst_n;
  logic              imem_hsel;
  htrans_e           imem_htrans;
  logic [ADDR_W-1:0] imem_haddr;
  logic              imem_hreadyout;
  logic [DATA_W-1:0] imem_hrdata;
  logic              imem_hresp;
  logic              dmem_hsel;
  htrans_e           dmem_htrans;
  logic [ADDR_W-1:0] dmem_haddr;
  logic              dmem_hwrite;
  logic [DATA_W-1:0] dmem_hwdata;
  logic              dmem_hreadyout;
  logic [DATA_W-1:0] dmem_hrdata;
  logic              dmem_hresp;

  // one stream per port
  logic [31:0]       lfsr_state [2];
  int                cycle_count = 0;
  // reference memory, missing words read as zero
  logic [DATA_W-1:0] model [int];

  main_memory i_dut (
    .clk_l2         (clk_l2),
    .clk_mem        (clk_mem),
    .rst_n          (rst_n),
    .imem_hsel      (imem_hsel),
    .imem_htrans    (imem_htrans),
    .imem_haddr     (imem_haddr),
    .imem_hreadyout (imem_hreadyout),
    .imem_hrdata    (imem_hrdata),
    .imem_hresp     (imem_hresp),
    .dmem_hsel      (dmem_hsel),
    .dmem_htrans    (dmem_htrans),
    .dmem_haddr     (dmem_haddr),
    .dmem_hwrite    (dmem_hwrite),
    .dmem_hwdata    (dmem_hwdata),
    .dmem_hreadyout (dmem_hreadyout),
    .dmem_hrdata    (dmem_hrdata),
    .dmem_hresp     (dmem_hresp)
  );

  task automatic fail_run();
    $display("test failed");
    $fatal(1);
  endtask

  `include "tb_util.svh"

  // --------------------
  // clocks and watchdog
  // --------------------

  always #4 clk_l2 = ~clk_l2;

  // same period, rising 3 ns after clk_l2
  initial
  begin
    clk_mem = 1'b1;
    #3 clk_mem = 1'b0;
    forever #4 clk_mem = ~clk_mem;
  end

  always @(posedge clk_l2)
    tick_watchdog();

  // --------------------
  // port access
  // --------------------

  function automatic string port_name(input int p);
    return (p == DMEM) ? "dmem" : "imem";
  endfunction

  function automatic logic [31:0] ready_of(input int p);
    return (p == DMEM) ? 32'(dmem_hreadyout) : 32'(imem_hreadyout);
  endfunction

  function automatic logic [31:0] resp_of(input int p);
    return (p == DMEM) ? 32'(dmem_hresp) : 32'(imem_hresp);
  endfunction

  function automatic logic [31:0] rdata_of(input int p);
    return (p == DMEM) ? dmem_hrdata : imem_hrdata;
  endfunction

  function automatic logic [31:0] model_read(input int idx);
    if (model.exists(idx))
      return model[idx];
    return '0;
  endfunction

  // imem has no write inputs
  task automatic drive_port(input int p, input bit sel, input htrans_e trans,
                            input logic [31:0] addr, input bit write,
                            input logic [31:0] wdata);
    if (p == DMEM)
    begin
      dmem_hsel   = sel;
      dmem_htrans = trans;
      dmem_haddr  = addr;
      dmem_hwrite = write;
      dmem_hwdata = wdata;
    end
    else
    begin
      imem_hsel   = sel;
      imem_htrans = trans;
      imem_haddr  = addr;
    end
  endtask

  // bus activity that must never start a transfer
  task automatic idle_cycles(input int p, input int n, input bit fresh);
    string   pfx;
    bit      sel;
    htrans_e trans;
    pfx = port_name(p);
    for (int i = 0; i < n; i++)
    begin
      sel = rand_bit(p);
      // selected but idle or busy
      if (sel)
        trans = htrans_e'({1'b0, rand_bit(p)});
      else
        trans = htrans_e'({rand_bit(p), rand_bit(p)});
      drive_port(p, sel, trans, rand_bits(p, 32), rand_bit(p), rand_bits(p, 32));
      @(posedge clk_l2);
      #1;
      check_value({pfx, "_hreadyout"}, ready_of(p), 32'd0);
      check_value({pfx, "_hresp"}, resp_of(p), 32'd0);
      if (fresh)
        check_value({pfx, "_hrdata"}, rdata_of(p), 32'd0);
    end
    drive_port(p, 1'b0, HTRANS_IDLE, '0, 1'b0, '0);
  endtask

  // one transfer, starts and ends 1 ns after a clk_l2 edge
  task automatic run_transfer(input int p, input logic [31:0] addr, input bit write,
                              input logic [31:0] wdata);
    string       pfx;
    bit          bad;
    bit          wr;
    int          idx;
    int          waited;
    logic [31:0] expected;
    pfx = port_name(p);
    // outside the mapped bytes or not word aligned
    bad = (addr >= 32'(MEM_BYTES)) || (addr[1:0] != 2'b00);
    wr  = write && (p == DMEM);
    idx = int'(addr[11:2]);
    expected = model_read(idx);
    if (!bad && wr)
      model[idx] = wdata;
    drive_port(p, 1'b1, htrans_e'({1'b1, rand_bit(p)}), addr, write, wdata);
    @(posedge clk_l2);
    #1;
    waited = 0;
    // stray requests while busy
    while (ready_of(p) == 32'd0)
    begin
      drive_port(p, rand_bit(p), htrans_e'({rand_bit(p), rand_bit(p)}),
                 rand_bits(p, 32), rand_bit(p), rand_bits(p, 32));
      @(posedge clk_l2);
      #1;
      waited++;
    end
    drive_port(p, 1'b0, HTRANS_IDLE, '0, 1'b0, '0);
    check_value({pfx, "_hresp"}, resp_of(p), 32'(bad));
    // error answer lands one edge after the accepting one
    if (bad)
      check_value({pfx, "_hreadyout_delay"}, waited, 32'd1);
    else if (!wr)
      check_value({pfx, "_hrdata"}, rdata_of(p), expected);
    @(posedge clk_l2);
    #1;
    // single pulse
    check_value({pfx, "_hreadyout"}, ready_of(p), 32'd0);
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial
  begin
    logic [31:0] word;
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] low;
    logic [31:0] d_word;
    logic [31:0] i_word;
    bit          write;
    bit          d_write;
    int          port;
    clk_l2      = 1'b0;
    rst_n       = 1'b0;
    imem_hsel   = 1'b0;
    imem_htrans = HTRANS_IDLE;
    imem_haddr  = '0;
    dmem_hsel   = 1'b0;
    dmem_htrans = HTRANS_IDLE;
    dmem_haddr  = '0;
    dmem_hwrite = 1'b0;
    dmem_hwdata = '0;
    lfsr_state[DMEM] = 32'h5c22_3ef4;
    lfsr_state[IMEM] = 32'h5c22_3ef4;
    // imem stream runs ahead
    void'(rand_bits(IMEM, 17));
    repeat (4) @(posedge clk_l2);
    #1 rst_n = 1'b1;

    // quiet outputs after reset
    fork
      idle_cycles(IMEM, 12, 1'b1);
      idle_cycles(DMEM, 12, 1'b1);
    join

    // data port alone, 64 words for frequent hits
    for (int i = 0; i < N_DATA; i++)
    begin
      write = rand_bit(DMEM);
      word  = rand_bits(DMEM, 6);
      data  = rand_bits(DMEM, 32);
      run_transfer(DMEM, word << 2, write, data);
      idle_cycles(DMEM, int'(rand_bit(DMEM)), 1'b0);
    end

    // illegal addresses, ports alternate
    for (int i = 0; i < N_ILLEGAL; i++)
    begin
      port = i % 2;
      word = rand_bits(port, 6);
      if (rand_bit(port))
        addr = (rand_bits(port, 20) << 12) | 32'h0000_1000 | (word << 2);
      else
      begin
        low  = rand_bits(port, 2);
        addr = (word << 2) | ((low == 32'd0) ? 32'd1 : low);
      end
      run_transfer(port, addr, 1'b1, rand_bits(port, 32));
      // aligned word must be untouched
      run_transfer(DMEM, word << 2, 1'b0, '0);
    end

    // write on dmem, fetch back on imem
    for (int i = 0; i < N_IMEM; i++)
    begin
      word = rand_bits(DMEM, 6);
      data = rand_bits(DMEM, 32);
      run_transfer(DMEM, word << 2, 1'b1, data);
      run_transfer(IMEM, word << 2, 1'b0, '0);
    end

    // both chains at once
    fork
      begin
        for (int i = 0; i < N_CONC; i++)
        begin
          d_write = rand_bit(DMEM);
          // writes kept to words 32..63, imem reads 0..31
          d_word  = d_write ? (32'd32 + rand_bits(DMEM, 5)) : rand_bits(DMEM, 6);
          run_transfer(DMEM, d_word << 2, d_write, rand_bits(DMEM, 32));
          idle_cycles(DMEM, rand_bits(DMEM, 2), 1'b0);
        end
      end
      begin
        for (int i = 0; i < N_CONC; i++)
        begin
          i_word = rand_bits(IMEM, 5);
          run_transfer(IMEM, i_word << 2, 1'b0, '0);
          idle_cycles(IMEM, rand_bits(IMEM, 2), 1'b0);
        end
      end
    join

    $display("test passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+test
common/mem_pkg.sv
common/mem_req_if.sv
common/mem_sram_if.sv
mem/mem_dual_sram.sv
mem/mem_port_decode.sv
mem/mem_access_sync.sv
mem/mem_port_result.sv
src/main_memory.sv
test/tb_main_memory.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_main_memory
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= test passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) test/tb_util.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
